// ==== hdl/rv_pkg.sv ====
package rv_pkg;

  // basic RV32 widths
  localparam int XLEN      = 32;
  localparam int ILEN      = 32;
  localparam int REG_IDX_W = 5;
  localparam int OPCODE_W  = 7;

  typedef logic [XLEN-1:0]      xlen_t;
  typedef logic [ILEN-1:0]      insn_t;
  typedef logic [REG_IDX_W-1:0] reg_idx_t;
  typedef logic [OPCODE_W-1:0]  opcode_t;

  // major opcodes of the supported subset
  localparam opcode_t OPC_LUI     = 7'b0110111;
  localparam opcode_t OPC_REG_IMM = 7'b0010011;
  localparam opcode_t OPC_REG_REG = 7'b0110011;
  localparam opcode_t OPC_BRANCH  = 7'b1100011;
  localparam opcode_t OPC_JAL     = 7'b1101111;
  localparam opcode_t OPC_ENVIRON = 7'b1110011;

  // funct3 for ALU operations
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // funct3 for branch conditions
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // selects SUB, SRA and SRAI
  localparam logic [6:0] FUNCT7_ALT = 7'b0100000;

  // what occupies a stage in a given cycle
  typedef enum logic [31:0] {
    CYCLE_INVALID      = 32'd0,
    CYCLE_RESET        = 32'd1,
    CYCLE_NO_STALL     = 32'd2,
    CYCLE_TAKEN_BRANCH = 32'd4
  } cycle_status_e;

  // execute-stage payload
  typedef struct packed {
    xlen_t         pc;
    insn_t         insn;
    cycle_status_e status;
    reg_idx_t      rs1;
    reg_idx_t      rs2;
    reg_idx_t      rd;
    xlen_t         rs1_val;
    xlen_t         rs2_val;
    logic          fwd_rs1;
    logic          fwd_rs2;
    xlen_t         fwd_rs1_val;
    xlen_t         fwd_rs2_val;
    xlen_t         imm_i;
    xlen_t         imm_b;
    xlen_t         imm_j;
  } exec_stage_t;

  // memory-stage payload, also the writeback register contents
  typedef struct packed {
    xlen_t         pc;
    insn_t         insn;
    cycle_status_e status;
    reg_idx_t      rd;
    xlen_t         rd_val;
    logic          we;
    logic          halt;
  } mem_stage_t;

endpackage

// ==== hdl/rv_regfile.sv ====
`timescale 1ns/100ps

module rv_regfile (
  input  logic             clk,
  input  logic             rst,
  input  logic             wr_en,
  input  rv_pkg::reg_idx_t wr_idx,
  input  rv_pkg::xlen_t    wr_data,
  input  rv_pkg::reg_idx_t rs1_idx,
  input  rv_pkg::reg_idx_t rs2_idx,
  output rv_pkg::xlen_t    rs1_data,
  output rv_pkg::xlen_t    rs2_data
);
  import rv_pkg::*;

  localparam int NUM_REGS = 2 ** $bits(reg_idx_t);

  xlen_t regs [NUM_REGS];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && wr_idx != '0) begin
      regs[wr_idx] <= wr_data;
    end
  end

  // x0 reads zero, a same-cycle write shows through
  always_comb begin
    if (rs1_idx == '0) begin
      rs1_data = '0;
    end else if (wr_en && wr_idx == rs1_idx) begin
      rs1_data = wr_data;
    end else begin
      rs1_data = regs[rs1_idx];
    end

    if (rs2_idx == '0) begin
      rs2_data = '0;
    end else if (wr_en && wr_idx == rs2_idx) begin
      rs2_data = wr_data;
    end else begin
      rs2_data = regs[rs2_idx];
    end
  end

endmodule

// ==== hdl/rv_fetch.sv ====
`timescale 1ns/100ps

module rv_fetch #(
  parameter rv_pkg::xlen_t RESET_PC = '0
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  branch_taken,
  input  rv_pkg::xlen_t         branch_target,
  input  rv_pkg::insn_t         insn_from_imem,
  output rv_pkg::xlen_t         pc_to_imem,
  output rv_pkg::xlen_t         d_pc,
  output rv_pkg::insn_t         d_insn,
  output rv_pkg::cycle_status_e d_status
);
  import rv_pkg::*;

  xlen_t pc_q;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pc_q <= RESET_PC;
    end else if (branch_taken) begin
      pc_q <= branch_target;
    end else begin
      pc_q <= pc_q + 32'd4;
    end
  end

  assign pc_to_imem = pc_q;

  // decode register, imem data arrives on the falling edge
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      d_pc     <= '0;
      d_insn   <= '0;
      d_status <= CYCLE_RESET;
    end else if (branch_taken) begin
      d_pc     <= '0;
      d_insn   <= '0;
      d_status <= CYCLE_TAKEN_BRANCH;
    end else begin
      d_pc     <= pc_q;
      d_insn   <= insn_from_imem;
      d_status <= CYCLE_NO_STALL;
    end
  end

endmodule

// ==== hdl/rv_decode.sv ====
`timescale 1ns/100ps

module rv_decode (
  input  logic                  clk,
  input  logic                  rst,
  input  rv_pkg::xlen_t         d_pc,
  input  rv_pkg::insn_t         d_insn,
  input  rv_pkg::cycle_status_e d_status,
  input  logic                  branch_taken,
  input  rv_pkg::mem_stage_t    mem_stage,
  input  logic                  wb_we,
  input  rv_pkg::reg_idx_t      wb_rd,
  input  rv_pkg::xlen_t         wb_data,
  output rv_pkg::exec_stage_t   x_stage
);
  import rv_pkg::*;

  reg_idx_t rs1;
  reg_idx_t rs2;
  reg_idx_t rd;
  xlen_t    rs1_val;
  xlen_t    rs2_val;
  xlen_t    imm_i;
  xlen_t    imm_b;
  xlen_t    imm_j;
  logic     fwd_rs1;
  logic     fwd_rs2;

  assign rs1 = d_insn[19:15];
  assign rs2 = d_insn[24:20];
  assign rd  = d_insn[11:7];

  // sign-extended immediates
  assign imm_i = {{20{d_insn[31]}}, d_insn[31:20]};
  assign imm_b = {{19{d_insn[31]}}, d_insn[31], d_insn[7], d_insn[30:25], d_insn[11:8], 1'b0};
  assign imm_j = {{11{d_insn[31]}}, d_insn[31], d_insn[19:12], d_insn[20], d_insn[30:21], 1'b0};

  rv_regfile i_regfile (
    .clk      (clk),
    .rst      (rst),
    .wr_en    (wb_we),
    .wr_idx   (wb_rd),
    .wr_data  (wb_data),
    .rs1_idx  (rs1),
    .rs2_idx  (rs2),
    .rs1_data (rs1_val),
    .rs2_data (rs2_val)
  );

  // memory-stage result will be in writeback once this insn reaches execute
  assign fwd_rs1 = mem_stage.we && mem_stage.rd != '0 && mem_stage.rd == rs1;
  assign fwd_rs2 = mem_stage.we && mem_stage.rd != '0 && mem_stage.rd == rs2;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      x_stage <= '{default: '0, status: CYCLE_RESET};
    end else if (branch_taken) begin
      x_stage <= '{default: '0, status: CYCLE_TAKEN_BRANCH};
    end else begin
      x_stage <= '{
        pc:          d_pc,
        insn:        d_insn,
        status:      d_status,
        rs1:         rs1,
        rs2:         rs2,
        rd:          rd,
        rs1_val:     rs1_val,
        rs2_val:     rs2_val,
        fwd_rs1:     fwd_rs1,
        fwd_rs2:     fwd_rs2,
        fwd_rs1_val: mem_stage.rd_val,
        fwd_rs2_val: mem_stage.rd_val,
        imm_i:       imm_i,
        imm_b:       imm_b,
        imm_j:       imm_j
      };
    end
  end

endmodule

// ==== hdl/rv_alu.sv ====
`timescale 1ns/100ps

module rv_alu (
  input  rv_pkg::exec_stage_t x_stage,
  input  rv_pkg::xlen_t       op_a,
  input  rv_pkg::xlen_t       op_b,
  output rv_pkg::xlen_t       result,
  output logic                rd_we,
  output logic                halt_req,
  output logic                branch_taken,
  output rv_pkg::xlen_t       branch_target
);
  import rv_pkg::*;

  opcode_t    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       f7_base;
  logic       f7_alt;
  logic [4:0] shamt_i;
  logic [4:0] shamt_r;
  logic       cond;

  assign opcode  = x_stage.insn[6:0];
  assign funct3  = x_stage.insn[14:12];
  assign funct7  = x_stage.insn[31:25];
  assign f7_base = funct7 == 7'b0;
  assign f7_alt  = funct7 == FUNCT7_ALT;
  assign shamt_i = x_stage.imm_i[4:0];
  assign shamt_r = op_b[4:0];

  // branch condition on the resolved operands
  always_comb begin
    case (funct3)
      F3_BEQ:  cond = op_a == op_b;
      F3_BNE:  cond = op_a != op_b;
      F3_BLT:  cond = $signed(op_a) < $signed(op_b);
      F3_BGE:  cond = $signed(op_a) >= $signed(op_b);
      F3_BLTU: cond = op_a < op_b;
      F3_BGEU: cond = op_a >= op_b;
      default: cond = 1'b0;
    endcase
  end

  assign branch_target = x_stage.pc + ((opcode == OPC_JAL) ? x_stage.imm_j : x_stage.imm_b);

  always_comb begin
    result       = '0;
    rd_we        = 1'b0;
    halt_req     = 1'b0;
    branch_taken = 1'b0;

    case (opcode)
      OPC_LUI: begin
        result = {x_stage.insn[31:12], 12'b0};
        rd_we  = 1'b1;
      end
      OPC_REG_IMM: begin
        rd_we = 1'b1;
        case (funct3)
          F3_ADD_SUB: result = op_a + x_stage.imm_i;
          F3_SLT:     result = {31'b0, $signed(op_a) < $signed(x_stage.imm_i)};
          F3_SLTU:    result = {31'b0, op_a < x_stage.imm_i};
          F3_XOR:     result = op_a ^ x_stage.imm_i;
          F3_OR:      result = op_a | x_stage.imm_i;
          F3_AND:     result = op_a & x_stage.imm_i;
          F3_SLL: begin
            result = op_a << shamt_i;
            rd_we  = f7_base;
          end
          default: begin
            // SRLI or SRAI
            result = f7_alt ? xlen_t'($signed(op_a) >>> shamt_i) : op_a >> shamt_i;
            rd_we  = f7_base || f7_alt;
          end
        endcase
      end
      OPC_REG_REG: begin
        // only ADD/SUB and the right shifts have an alternate form
        rd_we = f7_base || (f7_alt && (funct3 == F3_ADD_SUB || funct3 == F3_SRL_SRA));
        case (funct3)
          F3_ADD_SUB: result = f7_alt ? op_a - op_b : op_a + op_b;
          F3_SLL:     result = op_a << shamt_r;
          F3_SLT:     result = {31'b0, $signed(op_a) < $signed(op_b)};
          F3_SLTU:    result = {31'b0, op_a < op_b};
          F3_XOR:     result = op_a ^ op_b;
          F3_OR:      result = op_a | op_b;
          F3_AND:     result = op_a & op_b;
          default:    result = f7_alt ? xlen_t'($signed(op_a) >>> shamt_r) : op_a >> shamt_r;
        endcase
      end
      OPC_BRANCH: begin
        branch_taken = cond;
      end
      OPC_JAL: begin
        // link value
        result       = x_stage.pc + 32'd4;
        rd_we        = 1'b1;
        branch_taken = 1'b1;
      end
      OPC_ENVIRON: begin
        // ECALL only
        halt_req = x_stage.insn[31:7] == 25'b0;
      end
      default: begin
        rd_we = 1'b0;
      end
    endcase
  end

endmodule

// ==== hdl/rv_execute.sv ====
`timescale 1ns/100ps

module rv_execute (
  input  logic                clk,
  input  logic                rst,
  input  rv_pkg::exec_stage_t x_stage,
  output rv_pkg::mem_stage_t  mem_stage,
  output logic                branch_taken,
  output rv_pkg::xlen_t       branch_target
);
  import rv_pkg::*;

  xlen_t op_a;
  xlen_t op_b;
  xlen_t alu_result;
  logic  alu_we;
  logic  alu_halt;

  // newest value wins: memory stage, then decode-time capture, then regfile
  function automatic xlen_t pick_operand(reg_idx_t idx, xlen_t reg_val, logic fwd,
                                         xlen_t fwd_val, mem_stage_t mem);
    xlen_t val;
    val = fwd ? fwd_val : reg_val;
    if (mem.we && mem.rd != '0 && mem.rd == idx) begin
      val = mem.rd_val;
    end
    return val;
  endfunction

  assign op_a = pick_operand(x_stage.rs1, x_stage.rs1_val, x_stage.fwd_rs1,
                             x_stage.fwd_rs1_val, mem_stage);
  assign op_b = pick_operand(x_stage.rs2, x_stage.rs2_val, x_stage.fwd_rs2,
                             x_stage.fwd_rs2_val, mem_stage);

  rv_alu i_alu (
    .x_stage       (x_stage),
    .op_a          (op_a),
    .op_b          (op_b),
    .result        (alu_result),
    .rd_we         (alu_we),
    .halt_req      (alu_halt),
    .branch_taken  (branch_taken),
    .branch_target (branch_target)
  );

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      mem_stage <= '{default: '0, status: CYCLE_RESET};
    end else begin
      mem_stage <= '{
        pc:     x_stage.pc,
        insn:   x_stage.insn,
        status: x_stage.status,
        rd:     x_stage.rd,
        rd_val: alu_result,
        we:     alu_we,
        halt:   alu_halt
      };
    end
  end

endmodule

// ==== hdl/rv_retire.sv ====
`timescale 1ns/100ps

module rv_retire (
  input  logic                  clk,
  input  logic                  rst,
  input  rv_pkg::mem_stage_t    mem_stage,
  output logic                  wb_we,
  output rv_pkg::reg_idx_t      wb_rd,
  output rv_pkg::xlen_t         wb_data,
  output logic                  halt,
  output rv_pkg::xlen_t         trace_pc,
  output rv_pkg::insn_t         trace_insn,
  output rv_pkg::cycle_status_e trace_status
);
  import rv_pkg::*;

  mem_stage_t wb_q;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wb_q <= '{default: '0, status: CYCLE_RESET};
    end else begin
      wb_q <= mem_stage;
    end
  end

  // regfile write lands on the edge that ends this cycle
  assign wb_we   = wb_q.we;
  assign wb_rd   = wb_q.rd;
  assign wb_data = wb_q.rd_val;

  assign halt = wb_q.halt;

  // bubbles carry zero pc and insn
  assign trace_pc     = wb_q.pc;
  assign trace_insn   = wb_q.insn;
  assign trace_status = wb_q.status;

endmodule

// ==== hdl/rv_core.sv ====
`timescale 1ns/100ps

module rv_core #(
  parameter rv_pkg::xlen_t RESET_PC = '0
) (
  input  logic                  clk,
  input  logic                  rst,
  output rv_pkg::xlen_t         pc_to_imem,
  input  rv_pkg::insn_t         insn_from_imem,
  output logic                  halt,
  output rv_pkg::xlen_t         trace_pc,
  output rv_pkg::insn_t         trace_insn,
  output rv_pkg::cycle_status_e trace_status,
  output logic                  trace_we,
  output rv_pkg::reg_idx_t      trace_rd,
  output rv_pkg::xlen_t         trace_data
);
  import rv_pkg::*;

  xlen_t         d_pc;
  insn_t         d_insn;
  cycle_status_e d_status;
  exec_stage_t   x_stage;
  mem_stage_t    mem_stage;
  logic          branch_taken;
  xlen_t         branch_target;

  rv_fetch #(
    .RESET_PC (RESET_PC)
  ) i_fetch (
    .clk            (clk),
    .rst            (rst),
    .branch_taken   (branch_taken),
    .branch_target  (branch_target),
    .insn_from_imem (insn_from_imem),
    .pc_to_imem     (pc_to_imem),
    .d_pc           (d_pc),
    .d_insn         (d_insn),
    .d_status       (d_status)
  );

  // the writeback port doubles as the trace write port
  rv_decode i_decode (
    .clk          (clk),
    .rst          (rst),
    .d_pc         (d_pc),
    .d_insn       (d_insn),
    .d_status     (d_status),
    .branch_taken (branch_taken),
    .mem_stage    (mem_stage),
    .wb_we        (trace_we),
    .wb_rd        (trace_rd),
    .wb_data      (trace_data),
    .x_stage      (x_stage)
  );

  rv_execute i_execute (
    .clk           (clk),
    .rst           (rst),
    .x_stage       (x_stage),
    .mem_stage     (mem_stage),
    .branch_taken  (branch_taken),
    .branch_target (branch_target)
  );

  rv_retire i_retire (
    .clk          (clk),
    .rst          (rst),
    .mem_stage    (mem_stage),
    .wb_we        (trace_we),
    .wb_rd        (trace_rd),
    .wb_data      (trace_data),
    .halt         (halt),
    .trace_pc     (trace_pc),
    .trace_insn   (trace_insn),
    .trace_status (trace_status)
  );

endmodule

// ==== testbench/tb_core_chk.sv ====
`timescale 1ns/100ps

module tb_core_chk (
  input logic                  clk,
  input logic                  rst,
  input logic                  halt,
  input logic                  trace_we,
  input rv_pkg::cycle_status_e trace_status
);
  import rv_pkg::*;

  a_status_valid: assert property (
    @(posedge clk) disable iff (rst) trace_status != CYCLE_INVALID
  ) else $error("trace status is invalid after reset");

  // bubbles never write or halt
  a_bubble_quiet: assert property (
    @(posedge clk) disable iff (rst)
    (trace_status == CYCLE_RESET || trace_status == CYCLE_TAKEN_BRANCH) |-> (!trace_we && !halt)
  ) else $error("bubble cycle with write enable or halt set");

  a_halt_real: assert property (
    @(posedge clk) disable iff (rst) halt |-> trace_status == CYCLE_NO_STALL
  ) else $error("halt raised outside a retiring cycle");

endmodule

bind rv_core tb_core_chk i_chk (
  .clk          (clk),
  .rst          (rst),
  .halt         (halt),
  .trace_we     (trace_we),
  .trace_status (trace_status)
);

// ==== testbench/tb_core.sv ====
`timescale 1ns/100ps

module tb_core;
  import rv_pkg::*;

  localparam int N_RAND     = 40;
  localparam int BRANCH_LEN = 16;
  localparam int PROG_LEN   = N_RAND + BRANCH_LEN + 1;
  localparam int MAX_CYCLES = 16 + 4 + 3 * PROG_LEN + 20;

  logic          clk;
  logic          rst;
  xlen_t         pc_to_imem;
  insn_t         insn_from_imem;
  logic          halt;
  xlen_t         trace_pc;
  insn_t         trace_insn;
  cycle_status_e trace_status;
  logic          trace_we;
  reg_idx_t      trace_rd;
  xlen_t         trace_data;

  integer seed = 52;
  integer error_count = 0;
  integer cycle_count = 0;
  integer bubbles_due = 0;
  integer retired = 0;

  insn_t imem [PROG_LEN];

  // expected retirement list
  xlen_t    exp_pc [$];
  insn_t    exp_insn [$];
  logic     exp_we [$];
  reg_idx_t exp_rd [$];
  xlen_t    exp_val [$];
  logic     exp_redirect [$];
  logic     exp_halt [$];

  rv_core #(
    .RESET_PC (32'h0)
  ) i_dut (
    .clk            (clk),
    .rst            (rst),
    .pc_to_imem     (pc_to_imem),
    .insn_from_imem (insn_from_imem),
    .halt           (halt),
    .trace_pc       (trace_pc),
    .trace_insn     (trace_insn),
    .trace_status   (trace_status),
    .trace_we       (trace_we),
    .trace_rd       (trace_rd),
    .trace_data     (trace_data)
  );

  function automatic insn_t enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                  logic [4:0] rd, logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic insn_t enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                  logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OPC_REG_REG};
  endfunction

  function automatic insn_t enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                  logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  function automatic insn_t enc_j(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
  endfunction

  task automatic build_program();
    integer     kind;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [2:0] f3;
    logic       alt;
    logic [11:0] imm;
    integer     b;
    // dense reuse of x0..x7
    for (int i = 0; i < N_RAND; i++) begin
      kind = {$random(seed)} % 8;
      rd   = {$random(seed)} % 8;
      rs1  = {$random(seed)} % 8;
      rs2  = {$random(seed)} % 8;
      f3   = {$random(seed)} % 8;
      alt  = $random(seed);
      imm  = $random(seed);
      if (kind == 0) begin
        imem[i] = {$random(seed)} & 32'hffff_f000 | {rd, OPC_LUI};
      end else if (kind < 4) begin
        if (f3 == F3_SLL) begin
          imm = {7'b0, imm[4:0]};
        end else if (f3 == F3_SRL_SRA) begin
          imm = {(alt ? FUNCT7_ALT : 7'b0), imm[4:0]};
        end
        imem[i] = enc_i(imm, rs1, f3, rd, OPC_REG_IMM);
      end else begin
        alt = alt && (f3 == F3_ADD_SUB || f3 == F3_SRL_SRA);
        imem[i] = enc_r(alt ? FUNCT7_ALT : 7'b0, rs2, rs1, f3, rd);
      end
    end
    b = N_RAND;
    imem[b + 0]  = enc_i(12'd5, 5'd0, F3_ADD_SUB, 5'd1, OPC_REG_IMM);
    imem[b + 1]  = enc_i(-12'sd3, 5'd0, F3_ADD_SUB, 5'd2, OPC_REG_IMM);
    imem[b + 2]  = enc_b(13'd8, 5'd1, 5'd1, F3_BEQ);
    imem[b + 3]  = enc_i(12'd99, 5'd0, F3_ADD_SUB, 5'd3, OPC_REG_IMM);
    imem[b + 4]  = enc_b(13'd8, 5'd1, 5'd1, F3_BNE);
    imem[b + 5]  = enc_b(13'd8, 5'd1, 5'd2, F3_BLT);
    imem[b + 6]  = enc_i(12'd77, 5'd0, F3_ADD_SUB, 5'd4, OPC_REG_IMM);
    imem[b + 7]  = enc_b(13'd8, 5'd1, 5'd2, F3_BLTU);
    imem[b + 8]  = enc_b(13'd8, 5'd2, 5'd1, F3_BGE);
    imem[b + 9]  = enc_i(12'd55, 5'd0, F3_ADD_SUB, 5'd3, OPC_REG_IMM);
    imem[b + 10] = enc_b(13'd8, 5'd1, 5'd2, F3_BGEU);
    imem[b + 11] = enc_i(12'd1, 5'd0, F3_ADD_SUB, 5'd6, OPC_REG_IMM);
    imem[b + 12] = enc_j(21'd12, 5'd5);
    imem[b + 13] = enc_i(12'd2, 5'd0, F3_ADD_SUB, 5'd7, OPC_REG_IMM);
    imem[b + 14] = enc_i(12'd3, 5'd0, F3_ADD_SUB, 5'd7, OPC_REG_IMM);
    imem[b + 15] = enc_r(7'b0, 5'd1, 5'd5, F3_ADD_SUB, 5'd6);
    // ECALL
    imem[b + 16] = 32'h0000_0073;
  endtask

  // ISA-level model yielding one entry per retired insn
  function automatic void run_reference();
    logic [31:0] x [32];
    logic [31:0] pc;
    logic [31:0] insn;
    logic [31:0] a;
    logic [31:0] bv;
    logic [31:0] imm;
    logic [31:0] val;
    logic [31:0] next_pc;
    logic        we;
    logic        take;
    logic [2:0]  f3;
    logic        alt;
    for (int i = 0; i < 32; i++) begin
      x[i] = 0;
    end
    pc = 0;
    for (int step = 0; step < 4 * PROG_LEN; step++) begin
      insn    = imem[pc >> 2];
      a       = x[insn[19:15]];
      bv      = x[insn[24:20]];
      f3      = insn[14:12];
      alt     = insn[30];
      val     = 0;
      we      = 0;
      take    = 0;
      next_pc = pc + 4;
      if (insn == 32'h0000_0073) begin
        exp_pc.push_back(pc);
        exp_insn.push_back(insn);
        exp_we.push_back(1'b0);
        exp_rd.push_back(insn[11:7]);
        exp_val.push_back(0);
        exp_redirect.push_back(1'b0);
        exp_halt.push_back(1'b1);
        return;
      end
      case (insn[6:0])
        OPC_LUI: begin
          val = {insn[31:12], 12'h000};
          we  = 1;
        end
        OPC_REG_IMM, OPC_REG_REG: begin
          we = 1;
          if (insn[6:0] == OPC_REG_IMM) begin
            imm = {{20{insn[31]}}, insn[31:20]};
            bv  = imm;
          end
          case (f3)
            3'd0: val = (insn[6:0] == OPC_REG_REG && alt) ? a - bv : a + bv;
            3'd1: val = a << bv[4:0];
            3'd2: val = ($signed(a) < $signed(bv)) ? 1 : 0;
            3'd3: val = (a < bv) ? 1 : 0;
            3'd4: val = a ^ bv;
            3'd5: begin
              if (alt) begin
                val = $signed(a) >>> bv[4:0];
              end else begin
                val = a >> bv[4:0];
              end
            end
            3'd6: val = a | bv;
            default: val = a & bv;
          endcase
        end
        OPC_BRANCH: begin
          imm = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
          case (f3)
            3'd0: take = a == bv;
            3'd1: take = a != bv;
            3'd4: take = $signed(a) < $signed(bv);
            3'd5: take = $signed(a) >= $signed(bv);
            3'd6: take = a < bv;
            default: take = a >= bv;
          endcase
          if (take) begin
            next_pc = pc + imm;
          end
        end
        OPC_JAL: begin
          imm     = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
          val     = pc + 4;
          we      = 1;
          take    = 1;
          next_pc = pc + imm;
        end
        default: begin
          we = 0;
        end
      endcase
      exp_pc.push_back(pc);
      exp_insn.push_back(insn);
      exp_we.push_back(we);
      exp_rd.push_back(insn[11:7]);
      exp_val.push_back(val);
      exp_redirect.push_back(take);
      exp_halt.push_back(1'b0);
      if (we && insn[11:7] != 0) begin
        x[insn[11:7]] = val;
      end
      pc = next_pc;
    end
  endfunction

  task automatic check_field(string name, logic [31:0] expected, logic [31:0] actual);
    if (expected !== actual) begin
      $display("MISMATCH %s expected %h actual %h", name, expected, actual);
      error_count++;
    end
  endtask

  task automatic report_and_finish();
    $display("errors: %0d, retired: %0d", error_count, retired);
    if (error_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  endtask

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    rst            = 1'b1;
    insn_from_imem = '0;
    build_program();
    run_reference();
    repeat (16) @(negedge clk);
    rst = 1'b0;
  end

  // imem lookup on the falling edge
  always @(negedge clk) begin
    if ((pc_to_imem >> 2) < PROG_LEN) begin
      insn_from_imem = imem[pc_to_imem >> 2];
    end else begin
      insn_from_imem = '0;
    end
  end

  always @(posedge clk) begin
    if (!rst) begin
      cycle_count++;
      if (cycle_count >= MAX_CYCLES) begin
        $display("timeout after %0d cycles without ECALL retiring", cycle_count);
        error_count++;
        report_and_finish();
      end
    end
  end

  // trace compare at mid-cycle
  always @(negedge clk) begin
    string tag;
    if (cycle_count <= 3) begin
      check_field("reset.status", CYCLE_RESET, trace_status);
      check_field("reset.halt", 0, halt);
      check_field("reset.we", 0, trace_we);
      check_field("reset.pc", 0, trace_pc);
      check_field("reset.insn", 0, trace_insn);
    end else if (bubbles_due > 0) begin
      check_field("bubble.status", CYCLE_TAKEN_BRANCH, trace_status);
      check_field("bubble.halt", 0, halt);
      check_field("bubble.we", 0, trace_we);
      check_field("bubble.pc", 0, trace_pc);
      check_field("bubble.insn", 0, trace_insn);
      bubbles_due--;
    end else begin
      tag = $sformatf("retire[%0d]", retired);
      if (trace_status != CYCLE_NO_STALL) begin
        check_field({tag, ".status"}, CYCLE_NO_STALL, trace_status);
      end else if (exp_pc.size() == 0) begin
        $display("core retired an instruction after the expected list ran out");
        error_count++;
        report_and_finish();
      end else begin
        check_field({tag, ".pc"}, exp_pc[0], trace_pc);
        check_field({tag, ".insn"}, exp_insn[0], trace_insn);
        check_field({tag, ".we"}, exp_we[0], trace_we);
        check_field({tag, ".halt"}, exp_halt[0], halt);
        if (exp_we[0]) begin
          check_field({tag, ".rd"}, exp_rd[0], trace_rd);
          check_field({tag, ".data"}, exp_val[0], trace_data);
        end
        if (exp_redirect[0]) begin
          bubbles_due = 2;
        end
        retired++;
        void'(exp_pc.pop_front());
        void'(exp_insn.pop_front());
        void'(exp_we.pop_front());
        void'(exp_rd.pop_front());
        void'(exp_val.pop_front());
        void'(exp_redirect.pop_front());
        void'(exp_halt.pop_front());
        if (halt) begin
          if (exp_pc.size() != 0) begin
            $display("core halted with %0d expected entries left", exp_pc.size());
            error_count++;
          end
          report_and_finish();
        end
      end
    end
  end

endmodule

// ==== sources.f ====
hdl/rv_pkg.sv
hdl/rv_regfile.sv
hdl/rv_fetch.sv
hdl/rv_decode.sv
hdl/rv_alu.sv
hdl/rv_execute.sv
hdl/rv_retire.sv
hdl/rv_core.sv
testbench/tb_core_chk.sv
testbench/tb_core.sv

// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - hdl/rv_pkg.sv
  - hdl/rv_regfile.sv
  - hdl/rv_fetch.sv
  - hdl/rv_decode.sv
  - hdl/rv_alu.sv
  - hdl/rv_execute.sv
  - hdl/rv_retire.sv
  - hdl/rv_core.sv
  - target: test
    files:
      - testbench/tb_core_chk.sv
      - testbench/tb_core.sv
